/* clock_pkg.sv */
package clock_pkg;

   ////////////////////////////////////////////////////////////////////////
   // time word and digit limits
   ////////////////////////////////////////////////////////////////////////

   localparam logic [3:0] TENS_MAX = 4'd5;   // 5x tens for both fields
   localparam logic [3:0] ONES_MAX = 4'd9;

   // mm:ss, most significant digit first
   typedef struct packed {
      logic [3:0] min10;
      logic [3:0] min1;
      logic [3:0] sec10;
      logic [3:0] sec1;
   } bcd_time_t;

   ////////////////////////////////////////////////////////////////////////
   // key pulses and mode
   ////////////////////////////////////////////////////////////////////////

   // one-cycle press pulses, bit order matches btn[4:0]
   typedef struct packed {
      logic mode;
      logic alarm_off;
      logic inc_min;
      logic inc_sec;
      logic func;        // set toggle in watch, start/stop in cook timer
   } clock_keys_t;

   // key bundle routed to a single core
   typedef struct packed {
      logic alarm_off;
      logic inc_min;
      logic inc_sec;
      logic func;
   } core_keys_t;

   typedef enum logic {
      MODE_WATCH = 1'b0,
      MODE_COOK  = 1'b1
   } clock_mode_t;

endpackage

/* button_sync.sv */
`timescale 1ns/1ps

module button_sync #(
   parameter int DEBOUNCE_CLKS = 1_000_000
) (
   input  logic                    clk,
   input  logic                    reset_p,
   input  logic [4:0]              btn,
   output clock_pkg::clock_keys_t  keys
);

   localparam int NUM_BTN = $bits(clock_pkg::clock_keys_t);
   localparam int CW      = $clog2(DEBOUNCE_CLKS + 1);

   logic [NUM_BTN-1:0] sync_q0;
   logic [NUM_BTN-1:0] sync_q1;
   logic [NUM_BTN-1:0] level;          // debounced button state
   logic [NUM_BTN-1:0] press;
   logic [CW-1:0]      stable_cnt [NUM_BTN];

   always_ff @(posedge clk or posedge reset_p) begin
      if (reset_p) begin
         sync_q0 <= '0;
         sync_q1 <= '0;
         level   <= '0;
         press   <= '0;
         for (int i = 0; i < NUM_BTN; i++) begin
            stable_cnt[i] <= '0;
         end
      end else begin
         sync_q0 <= btn;
         sync_q1 <= sync_q0;
         press   <= '0;
         for (int i = 0; i < NUM_BTN; i++) begin
            if (sync_q1[i] == level[i]) begin
               stable_cnt[i] <= '0;          // no change pending
            end else if (stable_cnt[i] == CW'(DEBOUNCE_CLKS - 1)) begin
               stable_cnt[i] <= '0;
               level[i]      <= sync_q1[i];
               press[i]      <= sync_q1[i];  // rising side only
            end else begin
               stable_cnt[i] <= stable_cnt[i] + 1'b1;
            end
         end
      end
   end

   assign keys = clock_pkg::clock_keys_t'(press);

endmodule

/* tick_gen.sv */
`timescale 1ns/1ps

module tick_gen #(
   parameter int CLKS_PER_SEC = 100_000_000
) (
   input  logic clk,
   input  logic reset_p,
   input  logic run,
   output logic sec_tick
);

   localparam int CW = (CLKS_PER_SEC > 1) ? $clog2(CLKS_PER_SEC) : 1;

   logic [CW-1:0] div_cnt;

   // counter restarts from zero whenever run drops,
   // so every start gives a full first second
   always_ff @(posedge clk or posedge reset_p) begin
      if (reset_p) begin
         div_cnt  <= '0;
         sec_tick <= 1'b0;
      end else if (!run) begin
         div_cnt  <= '0;
         sec_tick <= 1'b0;
      end else if (div_cnt == CW'(CLKS_PER_SEC - 1)) begin
         div_cnt  <= '0;
         sec_tick <= 1'b1;
      end else begin
         div_cnt  <= div_cnt + 1'b1;
         sec_tick <= 1'b0;
      end
   end

endmodule

/* bcd_time_counter.sv */
`timescale 1ns/1ps

module bcd_time_counter (
   input  logic                  clk,
   input  logic                  reset_p,
   input  logic                  load,
   input  clock_pkg::bcd_time_t  load_value,
   input  logic                  count_up,
   input  logic                  count_down,
   input  logic                  inc_sec,
   input  logic                  inc_min,
   output clock_pkg::bcd_time_t  time_value,
   output logic                  is_zero
);

   // 00..59 pair, wraps 59 -> 00
   function automatic logic [7:0] pair_up(input logic [3:0] tens, input logic [3:0] ones);
      logic [7:0] r;
      if (ones == clock_pkg::ONES_MAX) begin
         if (tens == clock_pkg::TENS_MAX)
            r = 8'h00;
         else
            r = {tens + 4'd1, 4'd0};
      end else begin
         r = {tens, ones + 4'd1};
      end
      return r;
   endfunction

   // 00..59 pair, wraps 00 -> 59
   function automatic logic [7:0] pair_down(input logic [3:0] tens, input logic [3:0] ones);
      logic [7:0] r;
      if (ones == 4'd0) begin
         if (tens == 4'd0)
            r = {clock_pkg::TENS_MAX, clock_pkg::ONES_MAX};
         else
            r = {tens - 4'd1, clock_pkg::ONES_MAX};
      end else begin
         r = {tens, ones - 4'd1};
      end
      return r;
   endfunction

   clock_pkg::bcd_time_t next_time;
   logic [7:0] sec_up, sec_dn, min_up, min_dn;
   logic       sec_at_max, sec_at_zero;

   assign sec_up      = pair_up(time_value.sec10, time_value.sec1);
   assign sec_dn      = pair_down(time_value.sec10, time_value.sec1);
   assign min_up      = pair_up(time_value.min10, time_value.min1);
   assign min_dn      = pair_down(time_value.min10, time_value.min1);
   assign sec_at_max  = {time_value.sec10, time_value.sec1} ==
                        {clock_pkg::TENS_MAX, clock_pkg::ONES_MAX};
   assign sec_at_zero = {time_value.sec10, time_value.sec1} == 8'h00;
   assign is_zero     = time_value == '0;

   always_comb begin
      next_time = time_value;
      if (load) begin
         next_time = load_value;
      end else if (count_up) begin
         {next_time.sec10, next_time.sec1} = sec_up;
         if (sec_at_max)
            {next_time.min10, next_time.min1} = min_up;   // carry, 59:59 -> 00:00
      end else if (count_down) begin
         if (!is_zero) begin                                // hold at 00:00
            {next_time.sec10, next_time.sec1} = sec_dn;
            if (sec_at_zero)
               {next_time.min10, next_time.min1} = min_dn;   // borrow
         end
      end else if (inc_sec) begin
         {next_time.sec10, next_time.sec1} = sec_up;       // no carry
      end else if (inc_min) begin
         {next_time.min10, next_time.min1} = min_up;
      end
   end

   always_ff @(posedge clk or posedge reset_p) begin
      if (reset_p)
         time_value <= '0;
      else
         time_value <= next_time;
   end

endmodule

/* mode_ctrl.sv */
`timescale 1ns/1ps

module mode_ctrl (
   input  logic                    clk,
   input  logic                    reset_p,
   input  clock_pkg::clock_keys_t  keys,
   input  clock_pkg::bcd_time_t    watch_time,
   input  clock_pkg::bcd_time_t    cook_time,
   output clock_pkg::core_keys_t   watch_keys,
   output clock_pkg::core_keys_t   cook_keys,
   output clock_pkg::clock_mode_t  mode,
   output clock_pkg::bcd_time_t    display
);

   clock_pkg::core_keys_t routed;

   always_ff @(posedge clk or posedge reset_p) begin
      if (reset_p)
         mode <= clock_pkg::MODE_WATCH;
      else if (keys.mode)
         mode <= (mode == clock_pkg::MODE_WATCH) ? clock_pkg::MODE_COOK
                                                 : clock_pkg::MODE_WATCH;
   end

   ////////////////////////////////////////////////////////////////////////
   // key steering, only the selected core sees presses
   ////////////////////////////////////////////////////////////////////////

   assign routed.alarm_off = keys.alarm_off;
   assign routed.inc_min   = keys.inc_min;
   assign routed.inc_sec   = keys.inc_sec;
   assign routed.func      = keys.func;

   always_comb begin
      watch_keys = '0;
      cook_keys  = '0;
      if (mode == clock_pkg::MODE_WATCH)
         watch_keys = routed;
      else
         cook_keys  = routed;
   end

   assign display = (mode == clock_pkg::MODE_COOK) ? cook_time : watch_time;

endmodule

/* watch_core.sv */
`timescale 1ns/1ps

module watch_core (
   input  logic                   clk,
   input  logic                   reset_p,
   input  clock_pkg::core_keys_t  keys,
   input  logic                   sec_tick,
   output clock_pkg::bcd_time_t   time_value
);

   clock_pkg::bcd_time_t cur_time;
   clock_pkg::bcd_time_t set_time;
   logic set_mode;
   logic set_load;   // entering set mode
   logic cur_load;   // leaving set mode

   assign set_load = keys.func & ~set_mode;
   assign cur_load = keys.func & set_mode;

   always_ff @(posedge clk or posedge reset_p) begin
      if (reset_p)
         set_mode <= 1'b0;
      else if (keys.func)
         set_mode <= ~set_mode;
   end

   // keeps running while the set time is edited
   bcd_time_counter cur_cnt (
      .clk        (clk),
      .reset_p    (reset_p),
      .load       (cur_load),
      .load_value (set_time),
      .count_up   (sec_tick),
      .count_down (1'b0),
      .inc_sec    (1'b0),
      .inc_min    (1'b0),
      .time_value (cur_time),
      .is_zero    ()
   );

   bcd_time_counter set_cnt (
      .clk        (clk),
      .reset_p    (reset_p),
      .load       (set_load),
      .load_value (cur_time),
      .count_up   (1'b0),
      .count_down (1'b0),
      .inc_sec    (keys.inc_sec & set_mode),
      .inc_min    (keys.inc_min & set_mode),
      .time_value (set_time),
      .is_zero    ()
   );

   assign time_value = set_mode ? set_time : cur_time;

endmodule

/* cook_timer_core.sv */
`timescale 1ns/1ps

module cook_timer_core #(
   parameter int TONE_BIT = 14
) (
   input  logic                   clk,
   input  logic                   reset_p,
   input  clock_pkg::core_keys_t  keys,
   input  logic                   sec_tick,
   output clock_pkg::bcd_time_t   time_value,
   output logic                   running,
   output logic                   alarm,
   output logic                   buzz
);

   clock_pkg::bcd_time_t set_time;
   clock_pkg::bcd_time_t down_time;
   logic                 down_zero;
   logic                 start;
   logic                 timeout;
   logic [TONE_BIT:0]    tone_div;

   assign start   = keys.func & ~running;
   assign timeout = running & down_zero;

   ////////////////////////////////////////////////////////////////////////
   // run flag and alarm
   ////////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk or posedge reset_p) begin
      if (reset_p) begin
         running <= 1'b0;
      end else if (timeout) begin
         running <= 1'b0;             // stops itself at 00:00
      end else if (keys.func) begin
         running <= ~running;
      end
   end

   always_ff @(posedge clk or posedge reset_p) begin
      if (reset_p)
         alarm <= 1'b0;
      else if (timeout)
         alarm <= 1'b1;
      else if (keys.alarm_off)
         alarm <= 1'b0;
   end

   // set time only editable while stopped
   bcd_time_counter set_cnt (
      .clk        (clk),
      .reset_p    (reset_p),
      .load       (1'b0),
      .load_value ('0),
      .count_up   (1'b0),
      .count_down (1'b0),
      .inc_sec    (keys.inc_sec & ~running),
      .inc_min    (keys.inc_min & ~running),
      .time_value (set_time),
      .is_zero    ()
   );

   bcd_time_counter down_cnt (
      .clk        (clk),
      .reset_p    (reset_p),
      .load       (start),
      .load_value (set_time),
      .count_up   (1'b0),
      .count_down (sec_tick & running),
      .inc_sec    (1'b0),
      .inc_min    (1'b0),
      .time_value (down_time),
      .is_zero    (down_zero)
   );

   ////////////////////////////////////////////////////////////////////////
   // buzzer tone from a free divider
   ////////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk or posedge reset_p) begin
      if (reset_p)
         tone_div <= '0;
      else
         tone_div <= tone_div + 1'b1;
   end

   assign buzz       = alarm ? tone_div[TONE_BIT] : 1'b0;
   assign time_value = running ? down_time : set_time;

endmodule

/* multi_clock_top.sv */
`timescale 1ns/1ps

module multi_clock_top #(
   parameter int CLKS_PER_SEC  = 100_000_000,
   parameter int DEBOUNCE_CLKS = 1_000_000,
   parameter int TONE_BIT      = 14
) (
   input  logic                    clk,
   input  logic                    reset_p,
   input  logic [4:0]              btn,
   output clock_pkg::bcd_time_t    display,
   output clock_pkg::clock_mode_t  mode,
   output logic                    running,
   output logic                    alarm,
   output logic                    buzz
);

   clock_pkg::clock_keys_t keys;
   clock_pkg::core_keys_t  watch_keys;
   clock_pkg::core_keys_t  cook_keys;
   clock_pkg::bcd_time_t   watch_time;
   clock_pkg::bcd_time_t   cook_time;
   logic                   watch_tick;
   logic                   cook_tick;

   button_sync #(.DEBOUNCE_CLKS(DEBOUNCE_CLKS)) button_sync_inst (
      .clk(clk), .reset_p(reset_p), .btn(btn), .keys(keys)
   );

   tick_gen #(.CLKS_PER_SEC(CLKS_PER_SEC)) watch_tick_inst (   // free running
      .clk(clk), .reset_p(reset_p), .run(1'b1), .sec_tick(watch_tick)
   );

   tick_gen #(.CLKS_PER_SEC(CLKS_PER_SEC)) cook_tick_inst (
      .clk(clk), .reset_p(reset_p), .run(running), .sec_tick(cook_tick)
   );

   mode_ctrl mode_ctrl_inst (
      .clk(clk), .reset_p(reset_p), .keys(keys),
      .watch_time(watch_time), .cook_time(cook_time),
      .watch_keys(watch_keys), .cook_keys(cook_keys),
      .mode(mode), .display(display)
   );

   watch_core watch_core_inst (
      .clk(clk), .reset_p(reset_p), .keys(watch_keys),
      .sec_tick(watch_tick), .time_value(watch_time)
   );

   cook_timer_core #(.TONE_BIT(TONE_BIT)) cook_timer_core_inst (
      .clk(clk), .reset_p(reset_p), .keys(cook_keys), .sec_tick(cook_tick),
      .time_value(cook_time), .running(running), .alarm(alarm), .buzz(buzz)
   );

endmodule

/* multi_clock_props.sv */
`timescale 1ns/1ps

module multi_clock_props #(
   parameter bit HAS_RUN_FLAGS = 1'b1
) (
   input logic                  clk,
   input logic                  reset_p,
   input clock_pkg::bcd_time_t  time_value,
   input logic                  running,
   input logic                  alarm
);

   int fail_count = 0;

   // both fields stay in 00..59
   tens_in_range: assert property (@(posedge clk) disable iff (reset_p)
      time_value.min10 <= clock_pkg::TENS_MAX && time_value.sec10 <= clock_pkg::TENS_MAX)
      else begin
         $error("tens digit above its limit");
         fail_count++;
      end

   ones_in_range: assert property (@(posedge clk) disable iff (reset_p)
      time_value.min1 <= clock_pkg::ONES_MAX && time_value.sec1 <= clock_pkg::ONES_MAX)
      else begin
         $error("ones digit above its limit");
         fail_count++;
      end

   // timeout clears running in the same edge that sets alarm
   if (HAS_RUN_FLAGS) begin : g_run_alarm
      run_alarm_excl: assert property (@(posedge clk) disable iff (reset_p)
         !(running && alarm))
         else begin
            $error("alarm and running high together");
            fail_count++;
         end
   end

endmodule

bind bcd_time_counter multi_clock_props #(.HAS_RUN_FLAGS(1'b0)) counter_props (
   .clk(clk), .reset_p(reset_p), .time_value(time_value), .running(1'b0), .alarm(1'b0)
);

bind multi_clock_top multi_clock_props top_props (
   .clk(clk), .reset_p(reset_p), .time_value(display), .running(running), .alarm(alarm)
);

/* tb_multi_clock.sv */
`timescale 1ns/1ps

module tb_multi_clock;

   localparam int CLKS_PER_SEC = 400;
   localparam int BTN_FUNC      = 0;   // btn bit order follows clock_keys_t
   localparam int BTN_INC_SEC   = 1;
   localparam int BTN_INC_MIN   = 2;
   localparam int BTN_ALARM_OFF = 3;
   localparam int BTN_MODE      = 4;

   logic                   clk;
   logic                   reset_p;
   logic [4:0]             btn;
   clock_pkg::bcd_time_t   display;
   clock_pkg::clock_mode_t mode;
   logic                   running;
   logic                   alarm;
   logic                   buzz;

   clock_pkg::bcd_time_t   exp_disp;
   clock_pkg::bcd_time_t   exp_disp_alt;   // one tick later is also fine
   clock_pkg::clock_mode_t exp_mode;
   logic                   exp_running;
   logic                   exp_alarm;
   clock_pkg::bcd_time_t   prev_disp = '0;
   clock_pkg::bcd_time_t   last_run_disp = '0;
   logic                   prev_running = 1'b0;
   logic [31:0]            lcg_state;
   event                   check_ev;

   multi_clock_top #(
      .CLKS_PER_SEC (CLKS_PER_SEC),
      .DEBOUNCE_CLKS(4),
      .TONE_BIT     (2)
   ) multi_clock_top_inst (
      .clk(clk), .reset_p(reset_p), .btn(btn), .display(display),
      .mode(mode), .running(running), .alarm(alarm), .buzz(buzz)
   );

   initial begin
      clk = 1'b0;
      forever #50 clk = ~clk;
   end

   //////////////////////////////////////////////////////////////////////
   // reference model and helpers
   //////////////////////////////////////////////////////////////////////

   function automatic logic [31:0] lcg_next(input logic [31:0] s);
      return s * 32'd1103515245 + 32'd12345;
   endfunction

   function automatic clock_pkg::bcd_time_t make_time(input int m, input int s);
      clock_pkg::bcd_time_t r;
      r.min10 = 4'(m / 10);
      r.min1  = 4'(m % 10);
      r.sec10 = 4'(s / 10);
      r.sec1  = 4'(s % 10);
      return r;
   endfunction

   // each field wraps 59 -> 00 on its own, no carry
   function automatic clock_pkg::bcd_time_t bcd_add_presses(
         input clock_pkg::bcd_time_t start, input int n_sec, input int n_min);
      int s;
      int m;
      s = (start.sec10 * 10 + start.sec1 + n_sec) % 60;
      m = (start.min10 * 10 + start.min1 + n_min) % 60;
      return make_time(m, s);
   endfunction

   function automatic clock_pkg::bcd_time_t one_sec_later(input clock_pkg::bcd_time_t t);
      int s;
      int m;
      s = t.sec10 * 10 + t.sec1 + 1;
      m = t.min10 * 10 + t.min1;
      if (s == 60) begin   // carry into minutes, 59:59 -> 00:00
         s = 0;
         m = (m + 1) % 60;
      end
      return make_time(m, s);
   endfunction

   task automatic abort_run();
      $display("Simulation FAILED");
      $fatal(1, "run stopped at first error");
   endtask

   task automatic press(input int idx);
      @(posedge clk);
      #5 btn[idx] = 1'b1;
      repeat (12) @(posedge clk);
      #5 btn[idx] = 1'b0;
      repeat (12) @(posedge clk);
   endtask

   task automatic expect_state(input clock_pkg::bcd_time_t d, input clock_pkg::bcd_time_t d_alt,
                               input clock_pkg::clock_mode_t md, input logic run,
                               input logic alm);
      exp_disp     = d;
      exp_disp_alt = d_alt;
      exp_mode     = md;
      exp_running  = run;
      exp_alarm    = alm;
      @(negedge clk);
      -> check_ev;
   endtask

   task automatic wait_running(input int limit);
      int n;
      n = 0;
      while (running !== 1'b1 && n < limit) begin
         @(negedge clk);
         n++;
      end
      assert (running === 1'b1) else begin
         $display("timeout, cook timer did not start running");
         abort_run();
      end
   endtask

   task automatic wait_alarm(input int limit);
      int n;
      n = 0;
      while (alarm !== 1'b1 && n < limit) begin
         @(negedge clk);
         n++;
      end
      assert (alarm === 1'b1) else begin
         $display("timeout, alarm did not rise after the countdown");
         abort_run();
      end
   endtask

   //////////////////////////////////////////////////////////////////////
   // comparison processes
   //////////////////////////////////////////////////////////////////////

   always @(check_ev) begin
      assert (display == exp_disp || display == exp_disp_alt) else begin
         $display("[FAIL] %0t display got %h expected %h or %h",
                  $time, display, exp_disp, exp_disp_alt);
         abort_run();
      end
      assert (mode == exp_mode) else begin
         $display("[FAIL] %0t mode got %0d expected %0d", $time, mode, exp_mode);
         abort_run();
      end
      assert (running === exp_running) else begin
         $display("[FAIL] %0t running got %b expected %b", $time, running, exp_running);
         abort_run();
      end
      assert (alarm === exp_alarm) else begin
         $display("[FAIL] %0t alarm got %b expected %b", $time, alarm, exp_alarm);
         abort_run();
      end
   end

   // countdown must never go up
   always @(negedge clk) begin
      if (running && prev_running && mode == clock_pkg::MODE_COOK) begin
         assert (display <= prev_disp) else begin
            $display("[FAIL] %0t display got %h after %h while running",
                     $time, display, prev_disp);
            abort_run();
         end
      end
      if (running)
         last_run_disp = display;
      prev_running = running;
      prev_disp    = display;
   end

   //////////////////////////////////////////////////////////////////////
   // stimulus
   //////////////////////////////////////////////////////////////////////

   initial begin
      clock_pkg::bcd_time_t t0;
      clock_pkg::bcd_time_t set_t;
      clock_pkg::bcd_time_t w0;
      int n_sec;
      int n_min;
      int toggles;
      int n;
      int prop_fails;
      logic last_buzz;

      reset_p   = 1'b1;
      btn       = '0;
      lcg_state = 32'h1482;
      repeat (8) @(posedge clk);
      #5 reset_p = 1'b0;

      expect_state('0, '0, clock_pkg::MODE_WATCH, 1'b0, 1'b0);
      assert (buzz === 1'b0) else begin
         $display("[FAIL] %0t buzz got %b expected 0", $time, buzz);
         abort_run();
      end

      // watch set mode, set register starts from the current time
      t0 = display;
      press(BTN_FUNC);
      expect_state(t0, one_sec_later(t0), clock_pkg::MODE_WATCH, 1'b0, 1'b0);
      t0 = display;
      lcg_state = lcg_next(lcg_state);
      n_min = 1 + int'(lcg_state[23:16] % 6);
      lcg_state = lcg_next(lcg_state);
      n_sec = 61 + int'(lcg_state[23:16] % 8);   // forces a seconds wrap
      repeat (n_min) press(BTN_INC_MIN);
      repeat (n_sec) press(BTN_INC_SEC);
      set_t = bcd_add_presses(t0, n_sec, n_min);
      expect_state(set_t, set_t, clock_pkg::MODE_WATCH, 1'b0, 1'b0);

      press(BTN_FUNC);   // back to the running watch
      expect_state(set_t, one_sec_later(set_t), clock_pkg::MODE_WATCH, 1'b0, 1'b0);

      // cook presses must leave the watch alone
      w0 = display;
      press(BTN_MODE);
      expect_state('0, '0, clock_pkg::MODE_COOK, 1'b0, 1'b0);
      repeat (3) press(BTN_INC_SEC);
      expect_state(make_time(0, 3), make_time(0, 3), clock_pkg::MODE_COOK, 1'b0, 1'b0);
      press(BTN_MODE);
      expect_state(w0, one_sec_later(w0), clock_pkg::MODE_WATCH, 1'b0, 1'b0);

      // cook countdown from 00:03
      press(BTN_MODE);
      expect_state(make_time(0, 3), make_time(0, 3), clock_pkg::MODE_COOK, 1'b0, 1'b0);
      press(BTN_FUNC);
      wait_running(20);
      wait_alarm(5 * CLKS_PER_SEC);
      assert (last_run_disp == '0) else begin
         $display("[FAIL] %0t display got %h expected 0000 at timeout", $time, last_run_disp);
         abort_run();
      end
      // stopped timer shows its set time again
      expect_state(make_time(0, 3), make_time(0, 3), clock_pkg::MODE_COOK, 1'b0, 1'b1);

      toggles   = 0;
      n         = 0;
      last_buzz = buzz;
      while (toggles < 3 && n < 40) begin
         @(negedge clk);
         if (buzz !== last_buzz)
            toggles++;
         last_buzz = buzz;
         n++;
      end
      assert (toggles >= 3) else begin
         $display("buzz did not toggle while alarm was high");
         abort_run();
      end

      press(BTN_ALARM_OFF);
      expect_state(make_time(0, 3), make_time(0, 3), clock_pkg::MODE_COOK, 1'b0, 1'b0);
      assert (buzz === 1'b0) else begin
         $display("[FAIL] %0t buzz got %b expected 0", $time, buzz);
         abort_run();
      end

      prop_fails = multi_clock_top_inst.top_props.fail_count
                 + multi_clock_top_inst.watch_core_inst.cur_cnt.counter_props.fail_count
                 + multi_clock_top_inst.watch_core_inst.set_cnt.counter_props.fail_count
                 + multi_clock_top_inst.cook_timer_core_inst.set_cnt.counter_props.fail_count
                 + multi_clock_top_inst.cook_timer_core_inst.down_cnt.counter_props.fail_count;
      if (prop_fails == 0) begin
         $display("Simulation PASSED");
         $finish;
      end else begin
         $display("%0d concurrent assertion failures", prop_fails);
         abort_run();
      end
   end

endmodule

/* verilog.f */
clock_pkg.sv
button_sync.sv
tick_gen.sv
bcd_time_counter.sv
mode_ctrl.sv
watch_core.sv
cook_timer_core.sv
multi_clock_top.sv
multi_clock_props.sv
tb_multi_clock.sv
